//--- build.f
+incdir+rtl
rtl/cpu_decode_pkg.sv
rtl/mem_bus_pkg.sv
rtl/load_align.sv
rtl/store_align.sv
rtl/mem_stage.sv
tb/tb_mem_stage.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_mem_stage
FILELIST = build.f

OBJ_DIR  = obj_dir
SIM      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SRCS     = $(shell grep -v '^+' $(FILELIST))
HDRS     = rtl/mem_stage_defines.svh
DATA     = tb/mem_stage_tests.txt

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(HDRS) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM) $(DATA)
	./$(SIM) | tee $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb/mem_stage_tests.txt
# op funct3 rd addr store_data priv resp user kind expected
# kind data: rd value, fault: cause, none: store strobe or 0
ld 0 5 00000004 00000000 3 0 0 data 00000001
ld 0 6 00000005 00000000 3 0 0 data ffffff8c
ld 4 7 00000005 00000000 0 0 0 data 0000008c
ld 0 8 00000006 00000000 3 0 0 data fffffff0
ld 4 9 00000007 00000000 1 0 0 data 000000a5
ld 1 10 00000006 00000000 3 0 0 data ffffa5f0
ld 5 11 00000004 00000000 0 0 0 data 00008c01
ld 1 12 00000004 00000000 3 0 0 data ffff8c01
ld 2 13 00000004 00000000 3 0 0 data a5f08c01
st 0 0 00000011 12345677 0 0 0 none 2
ld 2 14 00000010 00000000 0 0 0 data a5f07704
st 1 0 00000012 cafebeef 3 0 0 none c
ld 2 15 00000010 00000000 3 0 0 data beef7704
st 2 0 00000020 11223344 3 0 0 none f
ld 2 16 00000020 00000000 0 0 0 data 11223344
ld 1 17 00000005 00000000 3 0 0 fault 4
ld 2 18 00000006 00000000 3 0 0 fault 4
st 1 0 00000009 0000abcd 3 0 0 fault 6
st 2 0 0000000a 0000abcd 0 0 0 fault 6
ld 2 19 00000008 00000000 3 2 0 fault 5
ld 2 20 00000008 00000000 0 3 1 fault d
st 2 0 00000008 deadbeef 3 2 0 fault 7
st 0 0 00000008 deadbeef 0 2 1 fault f
ld 2 21 00000008 00000000 3 0 0 data a5f08c02
ld 0 0 00000004 00000000 0 0 0 none 0

//--- tb/tb_mem_stage.sv
`timescale 1ns/1ps

module tb_mem_stage;

    logic clk = 1'b0;
    logic rst_n;
    cpu_decode_pkg::priv_t   csr_priv_i;
    logic                    e2m_instr_valid_i;
    mem_bus_pkg::data_t      e2m_instr_i;
    cpu_decode_pkg::decode_t e2m_decode_i;
    mem_bus_pkg::addr_t      e2m_addr_i;
    mem_bus_pkg::data_t      e2m_store_data_i;
    logic                     m2wb_rd_write_o;
    cpu_decode_pkg::reg_idx_t m2wb_rd_waddr_o;
    mem_bus_pkg::data_t       m2wb_rd_wdata_o;
    logic                     stall_o, kill_o;
    mem_bus_pkg::cause_t      exc_cause_o;
    logic awvalid, awready, wvalid, wready, bvalid, bready, buser, wlast;
    logic arvalid, arready, rvalid, rready, ruser;
    mem_bus_pkg::addr_t awaddr, araddr;
    mem_bus_pkg::data_t wdata, rdata;
    mem_bus_pkg::strb_t wstrb;
    mem_bus_pkg::resp_t bresp, rresp;
    mem_bus_pkg::prot_t awprot, arprot;
    logic [7:0] awlen, arlen;
    logic [2:0] awsize, arsize;
    logic [1:0] awburst, arburst;

    // Slave model state, driven only by the slave block
    logic [31:0]        mem [0:255];
    int                 seed = 17;
    int                 ar_dly, aw_dly, w_dly, r_dly, b_dly;
    int                 ar_cycles, aw_cycles;
    logic               r_pend, b_pend, aw_got, w_got;
    logic [7:0]         ar_idx, aw_idx;
    mem_bus_pkg::data_t w_cap;
    mem_bus_pkg::strb_t strb_cap;
    mem_bus_pkg::prot_t ar_prot_cap, aw_prot_cap;
    mem_bus_pkg::resp_t cur_resp;  // Set by the test flow per line
    logic               cur_user;

    int test_errs, pass_cnt, fail_cnt;

    always #2 clk = ~clk;

    mem_stage u_dut (
        .clk(clk), .rst_n(rst_n), .csr_priv_i(csr_priv_i),
        .e2m_instr_valid_i(e2m_instr_valid_i), .e2m_instr_i(e2m_instr_i),
        .e2m_decode_i(e2m_decode_i), .e2m_addr_i(e2m_addr_i),
        .e2m_store_data_i(e2m_store_data_i),
        .m2wb_rd_write_o(m2wb_rd_write_o), .m2wb_rd_waddr_o(m2wb_rd_waddr_o),
        .m2wb_rd_wdata_o(m2wb_rd_wdata_o),
        .stall_o(stall_o), .kill_o(kill_o), .exc_cause_o(exc_cause_o),
        .m_axi_awvalid_o(awvalid), .m_axi_awready_i(awready), .m_axi_awaddr_o(awaddr),
        .m_axi_awlen_o(awlen), .m_axi_awsize_o(awsize), .m_axi_awburst_o(awburst),
        .m_axi_awprot_o(awprot),
        .m_axi_wvalid_o(wvalid), .m_axi_wready_i(wready), .m_axi_wdata_o(wdata),
        .m_axi_wstrb_o(wstrb), .m_axi_wlast_o(wlast),
        .m_axi_bvalid_i(bvalid), .m_axi_bready_o(bready), .m_axi_bresp_i(bresp),
        .m_axi_buser_i(buser),
        .m_axi_arvalid_o(arvalid), .m_axi_arready_i(arready), .m_axi_araddr_o(araddr),
        .m_axi_arlen_o(arlen), .m_axi_arsize_o(arsize), .m_axi_arburst_o(arburst),
        .m_axi_arprot_o(arprot),
        .m_axi_rvalid_i(rvalid), .m_axi_rready_o(rready), .m_axi_rdata_i(rdata),
        .m_axi_rresp_i(rresp), .m_axi_ruser_i(ruser)
    );

    // AXI slave with random ready and response delays
    always @(posedge clk) begin
        if (rst_n) begin
            {arready, awready, wready, rvalid, bvalid} <= 5'b0;
            {r_pend, b_pend, aw_got, w_got} <= 4'b0;
            {ar_dly, aw_dly, w_dly, r_dly, b_dly} <= '0;
            ar_cycles <= 0;
            aw_cycles <= 0;
            rdata <= '0;
            {rresp, bresp, ruser, buser} <= '0;
            for (int i = 0; i < 256; i++) mem[i] <= 32'ha5f0_8c00 ^ i;  // Preload pattern
        end else begin
            if (arvalid) ar_cycles <= ar_cycles + 1;
            if (awvalid) aw_cycles <= aw_cycles + 1;
            if (arvalid && arready) begin
                arready     <= 1'b0;
                ar_idx      <= araddr[9:2];
                ar_prot_cap <= arprot;
                r_pend      <= 1'b1;
                r_dly       <= $unsigned($random(seed)) % 4;
                ar_dly      <= $unsigned($random(seed)) % 4;
                check_beat(arlen, arsize, arburst);
            end else if (arvalid) begin
                if (ar_dly == 0) arready <= 1'b1;
                else ar_dly <= ar_dly - 1;
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
                r_pend <= 1'b0;
            end else if (r_pend && !rvalid) begin
                if (r_dly == 0) begin
                    rvalid <= 1'b1;
                    rdata  <= mem[ar_idx];
                    rresp  <= cur_resp;
                    ruser  <= cur_user;
                end else r_dly <= r_dly - 1;
            end
            if (awvalid && awready) begin
                awready     <= 1'b0;
                aw_got      <= 1'b1;
                aw_idx      <= awaddr[9:2];
                aw_prot_cap <= awprot;
                aw_dly      <= $unsigned($random(seed)) % 4;
                check_beat(awlen, awsize, awburst);
            end else if (awvalid) begin
                if (aw_dly == 0) awready <= 1'b1;
                else aw_dly <= aw_dly - 1;
            end
            if (wvalid && wready) begin
                wready   <= 1'b0;
                w_got    <= 1'b1;
                w_cap    <= wdata;
                strb_cap <= wstrb;
                w_dly    <= $unsigned($random(seed)) % 4;
                note_flag(wlast, "write beat sent without WLAST");
            end else if (wvalid) begin
                if (w_dly == 0) wready <= 1'b1;
                else w_dly <= w_dly - 1;
            end
            if (aw_got && w_got && !b_pend) begin
                aw_got <= 1'b0;
                w_got  <= 1'b0;
                b_pend <= 1'b1;
                b_dly  <= $unsigned($random(seed)) % 4;
                if (cur_resp == 2'b00) begin  // Merge only on OKAY
                    for (int k = 0; k < 4; k++)
                        if (strb_cap[k]) mem[aw_idx][8*k +: 8] <= w_cap[8*k +: 8];
                end
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
                b_pend <= 1'b0;
            end else if (b_pend && !bvalid) begin
                if (b_dly == 0) begin
                    bvalid <= 1'b1;
                    bresp  <= cur_resp;
                    buser  <= cur_user;
                end else b_dly <= b_dly - 1;
            end
        end
    end

    task automatic check_data(input mem_bus_pkg::data_t got, input mem_bus_pkg::data_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t: load data %h, expected %h", $time, got, exp);
            test_errs++;
        end
    endtask

    task automatic check_waddr(input cpu_decode_pkg::reg_idx_t got,
                               input cpu_decode_pkg::reg_idx_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t: write register x%0d, expected x%0d", $time, got, exp);
            test_errs++;
        end
    endtask

    task automatic check_cause(input mem_bus_pkg::cause_t got, input mem_bus_pkg::cause_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t: cause %0d, expected %0d", $time, got, exp);
            test_errs++;
        end
    endtask

    task automatic check_strb(input mem_bus_pkg::strb_t got, input mem_bus_pkg::strb_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t: write strobe %b, expected %b", $time, got, exp);
            test_errs++;
        end
    endtask

    task automatic check_prot(input mem_bus_pkg::prot_t got, input mem_bus_pkg::prot_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t: prot %b, expected %b", $time, got, exp);
            test_errs++;
        end
    endtask

    // Single beat of 4 bytes, INCR
    task automatic check_beat(input logic [7:0] len, input logic [2:0] size,
                              input logic [1:0] burst);
        if (len !== 8'd0 || size !== 3'b010 || burst !== 2'b01) begin
            $display("ERROR at %0t: burst len %0d size %0d type %0d, expected 0 2 1",
                     $time, len, size, burst);
            test_errs++;
        end
    endtask

    task automatic note_flag(input logic ok, input string what);
        if (!ok) begin
            $display("Wrong behavior at %0t: %s", $time, what);
            test_errs++;
        end
    endtask

    initial begin
        int          fd, n, cycles, ar0, aw0;
        string       line;
        logic [63:0] op, kind;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [31:0] addr, sdata, exp;
        logic [1:0]  priv, resp;
        logic        user, done, timed_out;
        logic        got_write, got_kill;
        mem_bus_pkg::data_t       got_data;
        mem_bus_pkg::cause_t      got_cause;
        cpu_decode_pkg::reg_idx_t got_waddr;

        rst_n = 1'b1;
        e2m_instr_valid_i = 1'b0;
        e2m_instr_i = '0;
        e2m_decode_i = '0;
        e2m_addr_i = '0;
        e2m_store_data_i = '0;
        csr_priv_i = '0;
        cur_resp = '0;
        cur_user = 1'b0;
        timed_out = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b0;
        fd = $fopen("tb/mem_stage_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test data file");
            timed_out = 1'b1;
        end
        n = 0;
        while (fd != 0 && !timed_out && $fgets(line, fd)) begin
            if (line.len() < 4 || line[0] == "#") continue;
            void'($sscanf(line, "%s %h %d %h %h %d %d %d %s %h",
                          op, f3, rd, addr, sdata, priv, resp, user, kind, exp));
            n++;
            test_errs = 0;
            @(posedge clk);
            cur_resp <= resp;
            cur_user <= user;
            ar0 = ar_cycles;
            aw0 = aw_cycles;
            e2m_instr_valid_i <= 1'b1;
            e2m_instr_i       <= {17'd0, f3, rd, 7'd0};
            e2m_decode_i      <= (op == "st") ? 2'b10 : 2'b01;
            e2m_addr_i        <= addr;
            e2m_store_data_i  <= sdata;
            csr_priv_i        <= priv;
            done = 1'b0;
            cycles = 0;
            while (!done && cycles < 200) begin
                @(negedge clk);
                if (e2m_instr_valid_i && !stall_o) begin
                    done      = 1'b1;
                    got_write = m2wb_rd_write_o;
                    got_kill  = kill_o;
                    got_data  = m2wb_rd_wdata_o;
                    got_cause = exc_cause_o;
                    got_waddr = m2wb_rd_waddr_o;
                end else cycles++;
            end
            if (!done) begin
                $display("Test %0d timed out waiting for the stage to complete", n);
                timed_out = 1'b1;
                fail_cnt++;
                break;
            end
            // Hold cycle with the same instruction still offered
            @(negedge clk);
            note_flag(stall_o && !kill_o && !m2wb_rd_write_o, "instruction completed twice");
            note_flag(!arvalid && !awvalid && !wvalid, "bus request issued again");
            if (kind == "fault") begin
                note_flag(got_kill, "kill not raised");
                note_flag(!got_write, "register written on exception");
                check_cause(got_cause, exp[4:0]);
                if (exp[4:0] == 5'd4 || exp[4:0] == 5'd6)
                    note_flag(ar_cycles == ar0 && aw_cycles == aw0,
                              "bus request seen for misaligned access");
            end else begin
                note_flag(!got_kill, "unexpected kill");
                note_flag(got_write == (kind == "data"), "wrong register write enable");
                if (kind == "data") begin
                    check_data(got_data, exp);
                    check_waddr(got_waddr, rd);
                end
                if (op == "st") begin
                    check_strb(strb_cap, exp[3:0]);
                    check_prot(aw_prot_cap, {2'b00, priv != 2'd0});
                end else check_prot(ar_prot_cap, {2'b00, priv != 2'd0});
            end
            if (test_errs == 0) pass_cnt++;
            else fail_cnt++;
            $display("test %0d %s", n, (test_errs == 0) ? "passed" : "failed");
            @(posedge clk);
            e2m_instr_valid_i <= 1'b0;
        end
        if (fd != 0) $fclose(fd);
        $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && !timed_out && n > 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- rtl/mem_stage.sv
`timescale 1ns/1ps
`include "mem_stage_defines.svh"

module mem_stage (
    input  logic                     clk,
    input  logic                     rst_n,
    input  cpu_decode_pkg::priv_t    csr_priv_i,

    // From execute
    input  logic                     e2m_instr_valid_i,
    input  mem_bus_pkg::data_t       e2m_instr_i,
    input  cpu_decode_pkg::decode_t  e2m_decode_i,
    input  mem_bus_pkg::addr_t       e2m_addr_i,
    input  mem_bus_pkg::data_t       e2m_store_data_i,

    // To writeback
    output logic                     m2wb_rd_write_o,
    output cpu_decode_pkg::reg_idx_t m2wb_rd_waddr_o,
    output mem_bus_pkg::data_t       m2wb_rd_wdata_o,

    // Pipeline control
    output logic                     stall_o,
    output logic                     kill_o,
    output mem_bus_pkg::cause_t      exc_cause_o,

    output logic                     m_axi_awvalid_o,
    input  logic                     m_axi_awready_i,
    output mem_bus_pkg::addr_t       m_axi_awaddr_o,
    output logic [7:0]               m_axi_awlen_o,
    output logic [2:0]               m_axi_awsize_o,
    output logic [1:0]               m_axi_awburst_o,
    output mem_bus_pkg::prot_t       m_axi_awprot_o,

    output logic                     m_axi_wvalid_o,
    input  logic                     m_axi_wready_i,
    output mem_bus_pkg::data_t       m_axi_wdata_o,
    output mem_bus_pkg::strb_t       m_axi_wstrb_o,
    output logic                     m_axi_wlast_o,

    input  logic                     m_axi_bvalid_i,
    output logic                     m_axi_bready_o,
    input  mem_bus_pkg::resp_t       m_axi_bresp_i,
    input  logic                     m_axi_buser_i,   // Set for page fault

    output logic                     m_axi_arvalid_o,
    input  logic                     m_axi_arready_i,
    output mem_bus_pkg::addr_t       m_axi_araddr_o,
    output logic [7:0]               m_axi_arlen_o,
    output logic [2:0]               m_axi_arsize_o,
    output logic [1:0]               m_axi_arburst_o,
    output mem_bus_pkg::prot_t       m_axi_arprot_o,

    input  logic                     m_axi_rvalid_i,
    output logic                     m_axi_rready_o,
    input  mem_bus_pkg::data_t       m_axi_rdata_i,
    input  mem_bus_pkg::resp_t       m_axi_rresp_i,
    input  logic                     m_axi_ruser_i    // Set for page fault
);

    mem_bus_pkg::mem_state_t  state_q, state_d;
    logic                     aw_sent_q, aw_sent_d;
    logic                     w_sent_q, w_sent_d;

    cpu_decode_pkg::funct3_t  funct3;
    logic                     is_load;
    logic                     is_store;
    logic                     load_misaligned;
    logic                     store_misaligned;
    logic                     misaligned;
    logic                     aw_done;
    logic                     w_done;
    logic                     complete;
    logic                     bus_err;
    logic                     page_err;
    mem_bus_pkg::prot_t       prot;

    assign funct3          = e2m_instr_i[14:12];
    assign m2wb_rd_waddr_o = e2m_instr_i[11:7];

    assign is_load  = e2m_decode_i[`DECODE_IS_LOAD];
    assign is_store = e2m_decode_i[`DECODE_IS_STORE] && !is_load;

    assign misaligned = (is_load && load_misaligned) || (is_store && store_misaligned);

    load_align u_load_align (
        .addr_i       (e2m_addr_i),
        .funct3_i     (funct3),
        .rdata_i      (m_axi_rdata_i),
        .misaligned_o (load_misaligned),
        .load_data_o  (m2wb_rd_wdata_o)
    );

    store_align u_store_align (
        .addr_i       (e2m_addr_i),
        .funct3_i     (funct3),
        .store_data_i (e2m_store_data_i),
        .misaligned_o (store_misaligned),
        .wdata_o      (m_axi_wdata_o),
        .wstrb_o      (m_axi_wstrb_o)
    );

    // Single beat, 4 bytes, INCR on both channels
    assign m_axi_awlen_o   = 8'd0;
    assign m_axi_arlen_o   = 8'd0;
    assign m_axi_awsize_o  = 3'b010;
    assign m_axi_arsize_o  = 3'b010;
    assign m_axi_awburst_o = 2'b01;
    assign m_axi_arburst_o = 2'b01;
    assign m_axi_wlast_o   = m_axi_wvalid_o;

    assign prot           = {2'b00, csr_priv_i != cpu_decode_pkg::PRIV_USER};
    assign m_axi_awprot_o = prot;
    assign m_axi_arprot_o = prot;
    assign m_axi_awaddr_o = e2m_addr_i;
    assign m_axi_araddr_o = e2m_addr_i;

    assign aw_done = aw_sent_q || m_axi_awready_i;
    assign w_done  = w_sent_q || m_axi_wready_i;

    always_comb begin
        state_d         = state_q;
        aw_sent_d       = aw_sent_q;
        w_sent_d        = w_sent_q;
        m_axi_arvalid_o = 1'b0;
        m_axi_awvalid_o = 1'b0;
        m_axi_wvalid_o  = 1'b0;
        m_axi_rready_o  = 1'b0;
        m_axi_bready_o  = 1'b0;
        stall_o         = 1'b0;
        complete        = 1'b0;
        bus_err         = 1'b0;
        page_err        = 1'b0;
        case (state_q)
            mem_bus_pkg::MS_ISSUE: begin
                if (e2m_instr_valid_i) begin
                    if (misaligned) begin
                        complete = 1'b1;  // No bus access at all
                        state_d  = mem_bus_pkg::MS_DONE_HOLD;
                    end else if (is_load) begin
                        stall_o         = 1'b1;
                        m_axi_arvalid_o = 1'b1;
                        if (m_axi_arready_i)
                            state_d = mem_bus_pkg::MS_WAIT;
                    end else if (is_store) begin
                        stall_o         = 1'b1;
                        m_axi_awvalid_o = !aw_sent_q;
                        m_axi_wvalid_o  = !w_sent_q;
                        aw_sent_d       = aw_done;
                        w_sent_d        = w_done;
                        // AW and W may finish in either order
                        if (aw_done && w_done) begin
                            aw_sent_d = 1'b0;
                            w_sent_d  = 1'b0;
                            state_d   = mem_bus_pkg::MS_WAIT;
                        end
                    end
                end
            end
            mem_bus_pkg::MS_WAIT: begin
                if (is_load) begin
                    m_axi_rready_o = 1'b1;
                    stall_o        = !m_axi_rvalid_i;
                    complete       = m_axi_rvalid_i;
                    bus_err        = (m_axi_rresp_i != mem_bus_pkg::RESP_OKAY);
                    page_err       = m_axi_ruser_i;
                end else begin
                    m_axi_bready_o = 1'b1;
                    stall_o        = !m_axi_bvalid_i;
                    complete       = m_axi_bvalid_i;
                    bus_err        = (m_axi_bresp_i != mem_bus_pkg::RESP_OKAY);
                    page_err       = m_axi_buser_i;
                end
                if (complete)
                    state_d = mem_bus_pkg::MS_DONE_HOLD;
            end
            mem_bus_pkg::MS_DONE_HOLD: begin
                // Hold off whatever execute presents next for one cycle
                stall_o = e2m_instr_valid_i;
                state_d = mem_bus_pkg::MS_ISSUE;
            end
            default: state_d = mem_bus_pkg::MS_ISSUE;
        endcase
    end

    assign kill_o = complete && (misaligned || bus_err);
    assign m2wb_rd_write_o = complete && is_load && !misaligned && !bus_err
                             && (m2wb_rd_waddr_o != 5'd0);

    // Misaligned wins, bus error decides between page and access fault
    always_comb begin
        if (misaligned)
            exc_cause_o = is_load ? `EXC_LOAD_MISALIGNED : `EXC_STORE_MISALIGNED;
        else if (is_load)
            exc_cause_o = page_err ? `EXC_LOAD_PAGE_FAULT : `EXC_LOAD_ACCESS_FAULT;
        else
            exc_cause_o = page_err ? `EXC_STORE_PAGE_FAULT : `EXC_STORE_ACCESS_FAULT;
    end

    always_ff @(posedge clk) begin
        if (rst_n) begin  // Active high
            state_q   <= mem_bus_pkg::MS_ISSUE;
            aw_sent_q <= 1'b0;
            w_sent_q  <= 1'b0;
        end else begin
            state_q   <= state_d;
            aw_sent_q <= aw_sent_d;
            w_sent_q  <= w_sent_d;
        end
    end

endmodule

//--- rtl/store_align.sv
`timescale 1ns/1ps

module store_align (
    input  mem_bus_pkg::addr_t      addr_i,
    input  cpu_decode_pkg::funct3_t funct3_i,
    input  mem_bus_pkg::data_t      store_data_i,
    output logic                    misaligned_o,
    output mem_bus_pkg::data_t      wdata_o,
    output mem_bus_pkg::strb_t      wstrb_o
);

    always_comb begin
        case (funct3_i[1:0])
            2'b01:   misaligned_o = addr_i[0];
            2'b10:   misaligned_o = (addr_i[1:0] != 2'b00);
            default: misaligned_o = 1'b0;
        endcase
    end

    // Copy the low bytes into every lane so the strobe alone places them
    always_comb begin
        case (funct3_i)
            cpu_decode_pkg::F3_BYTE: begin
                wdata_o = {4{store_data_i[7:0]}};
                wstrb_o = mem_bus_pkg::strb_t'(4'b0001 << addr_i[1:0]);
            end
            cpu_decode_pkg::F3_HALF: begin
                wdata_o = {2{store_data_i[15:0]}};
                wstrb_o = addr_i[1] ? 4'b1100 : 4'b0011;
            end
            cpu_decode_pkg::F3_WORD: begin
                wdata_o = store_data_i;
                wstrb_o = 4'b1111;
            end
            default: begin
                wdata_o = store_data_i;
                wstrb_o = 4'b0000;  // Not a store size
            end
        endcase
    end

endmodule

//--- rtl/load_align.sv
`timescale 1ns/1ps

module load_align (
    input  mem_bus_pkg::addr_t      addr_i,
    input  cpu_decode_pkg::funct3_t funct3_i,
    input  mem_bus_pkg::data_t      rdata_i,
    output logic                    misaligned_o,
    output mem_bus_pkg::data_t      load_data_o
);

    logic [7:0]  byte_lane;
    logic [15:0] half_lane;
    logic        is_unsigned;

    assign is_unsigned = funct3_i[2];  // LBU and LHU

    always_comb begin
        case (funct3_i[1:0])
            2'b01:   misaligned_o = addr_i[0];
            2'b10:   misaligned_o = (addr_i[1:0] != 2'b00);
            default: misaligned_o = 1'b0;
        endcase
    end

    // Pick the addressed lane from the bus word
    always_comb begin
        case (addr_i[1:0])
            2'b00:   byte_lane = rdata_i[7:0];
            2'b01:   byte_lane = rdata_i[15:8];
            2'b10:   byte_lane = rdata_i[23:16];
            default: byte_lane = rdata_i[31:24];
        endcase
    end

    assign half_lane = addr_i[1] ? rdata_i[31:16] : rdata_i[15:0];

    always_comb begin
        case (funct3_i[1:0])
            2'b00: begin
                if (is_unsigned)
                    load_data_o = {24'd0, byte_lane};
                else
                    load_data_o = {{24{byte_lane[7]}}, byte_lane};
            end
            2'b01: begin
                if (is_unsigned)
                    load_data_o = {16'd0, half_lane};
                else
                    load_data_o = {{16{half_lane[15]}}, half_lane};
            end
            default: load_data_o = rdata_i;  // Full word
        endcase
    end

endmodule

//--- rtl/mem_bus_pkg.sv
`include "mem_stage_defines.svh"

package mem_bus_pkg;

    typedef logic [`MEM_XLEN-1:0]   addr_t;
    typedef logic [`MEM_XLEN-1:0]   data_t;
    typedef logic [`MEM_XLEN/8-1:0] strb_t;  // One bit per byte lane

    typedef logic [1:0] resp_t;   // OKAY is zero
    typedef logic [2:0] prot_t;   // Bit 0 privileged

    // mcause value reported with kill
    typedef logic [4:0] cause_t;

    // Transaction state of the open instruction
    typedef enum logic [1:0] {
        MS_ISSUE,      // AR or AW/W still pending
        MS_WAIT,       // Waiting for R or B
        MS_DONE_HOLD   // Execute is moving on
    } mem_state_t;

    localparam resp_t RESP_OKAY = 2'b00;

endpackage

//--- rtl/cpu_decode_pkg.sv
`include "mem_stage_defines.svh"

package cpu_decode_pkg;

    // One bit per memory operation class
    typedef logic [`DECODE_IS_WIDTH-1:0] decode_t;

    // Destination register, instr[11:7]
    typedef logic [4:0] reg_idx_t;

    // Size in [1:0], unsigned in [2]
    typedef logic [2:0] funct3_t;

    // Privilege level, 0 user, 3 machine
    typedef logic [1:0] priv_t;

    localparam funct3_t F3_BYTE = 3'b000;
    localparam funct3_t F3_HALF = 3'b001;
    localparam funct3_t F3_WORD = 3'b010;

    localparam priv_t PRIV_USER = 2'd0;

endpackage

//--- rtl/mem_stage_defines.svh
`ifndef MEM_STAGE_DEFINES_SVH
`define MEM_STAGE_DEFINES_SVH

// Datapath and bus width
`define MEM_XLEN 32

// Decode vector from execute
`define DECODE_IS_WIDTH 2
`define DECODE_IS_LOAD  0
`define DECODE_IS_STORE 1

// RISC-V mcause values for memory exceptions
`define EXC_LOAD_MISALIGNED    5'd4
`define EXC_LOAD_ACCESS_FAULT  5'd5
`define EXC_STORE_MISALIGNED   5'd6
`define EXC_STORE_ACCESS_FAULT 5'd7
`define EXC_LOAD_PAGE_FAULT    5'd13
`define EXC_STORE_PAGE_FAULT   5'd15

`endif
